//--- hw/vic_consts.svh
`ifndef VIC_CONSTS_SVH
`define VIC_CONSTS_SVH

// clk_dot4x ticks per phi cycle
`define VIC_PHASES        32

// phi cycles per raster line
`define VIC_CYC_NTSC      65
`define VIC_CYC_PAL       63

// raster lines per frame
`define VIC_LINES_NTSC    263
`define VIC_LINES_PAL     312

// sync windows, pixels and lines
`define VIC_HSYNC_START   416
`define VIC_HSYNC_LEN     40
`define VIC_VSYNC_LINE    4
`define VIC_VSYNC_LEN     3

// display window, inclusive on both ends
`define VIC_DISP_X0       24
`define VIC_DISP_X1       343
`define VIC_DISP_Y0       51
`define VIC_DISP_Y1       250

// visible area, X1 and Y1 are the first blanked pixel / line
`define VIC_VIS_X1        400
`define VIC_VIS_Y0        16
`define VIC_VIS_Y1        260

// register map, low 6 address bits
`define VIC_REG_CTRL1     6'h11   // bit 7 is raster bit 8
`define VIC_REG_RASTER    6'h12
`define VIC_REG_IRQ       6'h19
`define VIC_REG_IRQEN     6'h1A
`define VIC_REG_BORDER    6'h20
`define VIC_REG_BG        6'h21

// dram refresh row base
`define VIC_REF_BASE      14'h3F00

`endif

//--- hw/vic_pkg.sv
package vic_pkg;

  // chip model, picks line and frame size
  typedef enum logic [1:0] {
    chip_ntsc = 2'd0,
    chip_pal  = 2'd1
  } chip_t;

  typedef logic [3:0] color_t;     // palette index
  typedef logic [5:0] reg_addr_t;  // adl[5:0]
  typedef logic [4:0] phase_t;     // position in one phi cycle

  // 2 bits per gun, to the video dac
  typedef struct packed {
    logic [1:0] red;
    logic [1:0] green;
    logic [1:0] blue;
  } rgb2_t;

  // rough 2-bit version of the 16 colour palette
  localparam rgb2_t vic_palette [0:15] = '{
    '{2'd0, 2'd0, 2'd0},  // black
    '{2'd3, 2'd3, 2'd3},  // white
    '{2'd2, 2'd0, 2'd0},  // red
    '{2'd1, 2'd3, 2'd3},  // cyan
    '{2'd2, 2'd0, 2'd2},  // purple
    '{2'd1, 2'd2, 2'd0},  // green
    '{2'd0, 2'd0, 2'd2},  // blue
    '{2'd3, 2'd3, 2'd1},  // yellow
    '{2'd2, 2'd1, 2'd0},  // orange
    '{2'd1, 2'd1, 2'd0},  // brown
    '{2'd3, 2'd1, 2'd1},  // light red
    '{2'd1, 2'd1, 2'd1},  // dark grey
    '{2'd2, 2'd2, 2'd2},  // grey
    '{2'd2, 2'd3, 2'd1},  // light green
    '{2'd1, 2'd1, 2'd3},  // light blue
    '{2'd3, 2'd3, 2'd2}   // light grey
  };

endpackage : vic_pkg

//--- hw/clk_div4.sv
`timescale 1ns/1ps

// colour ref clock = clk_col4x / 4
module clk_div4 (
  input  logic clk_col4x,
  input  logic arst_n,
  output logic clk_colref
);

  logic [1:0] div_cnt;

  always_ff @(posedge clk_col4x or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= 2'd0;
    end else begin
      div_cnt <= div_cnt + 2'd1;  // free running
    end
  end

  // msb toggles every 2 input cycles, 50% duty
  assign clk_colref = div_cnt[1];

endmodule : clk_div4

//--- hw/bus_sequencer.sv
`timescale 1ns/1ps

`include "vic_consts.svh"

// one phi cycle = 32 dot4x ticks, first half vic owns the bus
module bus_sequencer (
  input  logic        clk_dot4x,
  input  logic        arst_n,
  input  logic        ce,            // low = cpu selects vic
  input  logic        rw,            // high read, low write
  output logic        clk_phi,
  output logic        aec,
  output logic        ras,
  output logic        cas,
  output logic [11:0] ado,
  output logic        vic_write_ab,
  output logic        vic_write_db,
  output logic        ls245_oe,
  output logic        ls245_dir,
  output logic        wr_stb,
  output logic        dot_tick
);
  import vic_pkg::*;

  localparam phase_t PH_LAST = phase_t'(`VIC_PHASES - 1);
  localparam phase_t PH_HALF = phase_t'(`VIC_PHASES / 2);
  localparam phase_t RAS_ON  = 5'd6;   // vic refresh row strobe
  localparam phase_t RAS_OFF = 5'd13;
  localparam phase_t CAS_ON  = 5'd22;  // cpu side dram column strobe
  localparam phase_t CAS_OFF = 5'd29;

  phase_t      phase;
  phase_t      phase_nxt;
  logic        cpu_sel;    // cpu talking to vic this half cycle
  logic [7:0]  ref_cnt;    // refresh row counter
  logic [13:0] ref_addr;

  assign phase_nxt = (phase == PH_LAST) ? 5'd0 : phase + 5'd1;

  // outputs decoded from the next phase so they line up with phase
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      phase        <= 5'd0;
      clk_phi      <= 1'b0;
      vic_write_ab <= 1'b0;
      ras          <= 1'b1;
      cas          <= 1'b1;
      cpu_sel      <= 1'b0;
    end else begin
      phase        <= phase_nxt;
      clk_phi      <= (phase_nxt >= PH_HALF);  // low first half
      vic_write_ab <= (phase_nxt < PH_HALF);   // vic drives address while phi low
      ras          <= !((phase_nxt >= RAS_ON) && (phase_nxt <= RAS_OFF));
      // ce high means the cpu is going to dram, not to us
      cas          <= !(ce && (phase_nxt >= CAS_ON) && (phase_nxt <= CAS_OFF));
      cpu_sel      <= !ce && (phase_nxt >= PH_HALF);
    end
  end

  // one row per phi cycle
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      ref_cnt <= 8'd0;
    end else if (phase == PH_LAST) begin
      ref_cnt <= ref_cnt + 8'd1;  // held stable through next low half
    end
  end

  assign ref_addr = `VIC_REF_BASE | {6'd0, ref_cnt};
  assign ado      = {ref_addr[13:8], ref_addr[5:0]};  // adh = row base, adl = refresh

  assign aec          = clk_phi;            // cpu gets the bus on phi high
  assign vic_write_db = cpu_sel & rw;       // cpu read, vic drives data
  assign ls245_oe     = !cpu_sel;
  assign ls245_dir    = rw;

  // write data sampled at the very end of phi high
  assign wr_stb   = (phase == PH_LAST) && cpu_sel && !rw;
  assign dot_tick = (phase[1:0] == 2'b11);  // 8 pixels per phi

endmodule : bus_sequencer

//--- hw/raster_counter.sv
`timescale 1ns/1ps

`include "vic_consts.svh"

module raster_counter (
  input  logic           clk_dot4x,
  input  logic           arst_n,
  input  vic_pkg::chip_t chip,
  input  logic           dot_tick,
  output logic [8:0]     xpos,
  output logic [8:0]     raster,
  output logic           line_stb,  // one clock, after raster moved on
  output logic           hsync,
  output logic           vsync,
  output logic           csync
);
  import vic_pkg::*;

  localparam logic [9:0] NTSC_PX_LAST = 10'(`VIC_CYC_NTSC * 8 - 1);
  localparam logic [9:0] PAL_PX_LAST  = 10'(`VIC_CYC_PAL * 8 - 1);
  localparam logic [8:0] NTSC_LN_LAST = 9'(`VIC_LINES_NTSC - 1);
  localparam logic [8:0] PAL_LN_LAST  = 9'(`VIC_LINES_PAL - 1);
  localparam logic [9:0] HS_START     = 10'(`VIC_HSYNC_START);
  localparam logic [9:0] HS_END       = 10'(`VIC_HSYNC_START + `VIC_HSYNC_LEN);
  localparam logic [8:0] VS_START     = 9'(`VIC_VSYNC_LINE);
  localparam logic [8:0] VS_END       = 9'(`VIC_VSYNC_LINE + `VIC_VSYNC_LEN);

  logic [9:0] px_cnt;   // 520 pixels on ntsc, needs the extra bit
  logic [9:0] px_last;
  logic [8:0] ln_last;
  logic       eol;

  assign px_last = (chip == chip_pal) ? PAL_PX_LAST : NTSC_PX_LAST;
  assign ln_last = (chip == chip_pal) ? PAL_LN_LAST : NTSC_LN_LAST;

  // >= keeps things sane if chip flips mid line
  assign eol = dot_tick && (px_cnt >= px_last);

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      px_cnt   <= 10'd0;
      raster   <= 9'd0;
      line_stb <= 1'b0;
    end else begin
      line_stb <= eol;
      if (eol) begin
        px_cnt <= 10'd0;
        raster <= (raster >= ln_last) ? 9'd0 : raster + 9'd1;  // frame wrap
      end else if (dot_tick) begin
        px_cnt <= px_cnt + 10'd1;
      end
    end
  end

  // active low sync, registered
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= !((px_cnt >= HS_START) && (px_cnt < HS_END));
      vsync <= !((raster >= VS_START) && (raster < VS_END));
    end
  end

  assign csync = hsync & vsync;  // low during either pulse

  // pixels past 511 sit in horizontal blank, clamp them there
  assign xpos = px_cnt[9] ? 9'h1FF : px_cnt[8:0];

endmodule : raster_counter

//--- hw/reg_file.sv
`timescale 1ns/1ps

`include "vic_consts.svh"

module reg_file (
  input  logic               clk_dot4x,
  input  logic               arst_n,
  input  vic_pkg::reg_addr_t adi,
  input  logic [7:0]         dbi,
  input  logic               wr_stb,
  input  logic [8:0]         raster,
  input  logic               line_stb,
  output logic [7:0]         dbo,
  output logic               irq,         // open drain style, low active
  output vic_pkg::color_t    border,
  output vic_pkg::color_t    background
);
  import vic_pkg::*;

  localparam reg_addr_t A_CTRL1  = `VIC_REG_CTRL1;
  localparam reg_addr_t A_RASTER = `VIC_REG_RASTER;
  localparam reg_addr_t A_IRQ    = `VIC_REG_IRQ;
  localparam reg_addr_t A_IRQEN  = `VIC_REG_IRQEN;
  localparam reg_addr_t A_BORDER = `VIC_REG_BORDER;
  localparam reg_addr_t A_BG     = `VIC_REG_BG;

  logic [7:0] ctrl1_q;     // bit 7 = compare bit 8
  logic [7:0] rast_cmp_q;  // compare low byte
  logic [3:0] irq_en_q;    // only bit 0 (raster) has a source here
  logic       irq_st_q;    // raster irq latched
  logic [7:0] bdr_q;
  logic [7:0] bg_q;
  logic [8:0] cmp_line;
  logic       raster_hit;
  logic       irq_ack;
  logic       irq_act;

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      ctrl1_q    <= 8'd0;
      rast_cmp_q <= 8'd0;
      irq_en_q   <= 4'd0;
      bdr_q      <= 8'd0;
      bg_q       <= 8'd0;
    end else if (wr_stb) begin
      case (adi)
        A_CTRL1:  ctrl1_q    <= dbi;
        A_RASTER: rast_cmp_q <= dbi;  // write sets compare, read gives line
        A_IRQEN:  irq_en_q   <= dbi[3:0];
        A_BORDER: bdr_q      <= dbi;
        A_BG:     bg_q       <= dbi;
        default:  ;
      endcase
    end
  end

  assign cmp_line   = {ctrl1_q[7], rast_cmp_q};
  assign raster_hit = line_stb && (raster == cmp_line);   // once per matching line
  assign irq_ack    = wr_stb && (adi == A_IRQ) && dbi[0];  // write 1 to clear

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      irq_st_q <= 1'b0;
    end else if (raster_hit) begin
      irq_st_q <= 1'b1;   // new event beats a same cycle ack
    end else if (irq_ack) begin
      irq_st_q <= 1'b0;
    end
  end

  assign irq_act = irq_st_q & irq_en_q[0];
  assign irq     = !irq_act;

  // cpu reads, straight off adi
  always_comb begin
    case (adi)
      A_CTRL1:  dbo = {raster[8], ctrl1_q[6:0]};
      A_RASTER: dbo = raster[7:0];
      A_IRQ:    dbo = {irq_act, 3'b111, 3'b000, irq_st_q};  // unused bits float high
      A_IRQEN:  dbo = {4'hF, irq_en_q};
      A_BORDER: dbo = bdr_q;
      A_BG:     dbo = bg_q;
      default:  dbo = 8'hFF;
    endcase
  end

  assign border     = color_t'(bdr_q[3:0]);
  assign background = color_t'(bg_q[3:0]);

endmodule : reg_file

//--- hw/pixel_out.sv
`timescale 1ns/1ps

`include "vic_consts.svh"

module pixel_out (
  input  logic            clk_dot4x,
  input  logic            arst_n,
  input  logic [8:0]      xpos,
  input  logic [8:0]      raster,
  input  vic_pkg::color_t border,
  input  vic_pkg::color_t background,
  output vic_pkg::rgb2_t  rgb
);
  import vic_pkg::*;

  localparam logic [8:0] DISP_X0 = 9'(`VIC_DISP_X0);
  localparam logic [8:0] DISP_X1 = 9'(`VIC_DISP_X1);
  localparam logic [8:0] DISP_Y0 = 9'(`VIC_DISP_Y0);
  localparam logic [8:0] DISP_Y1 = 9'(`VIC_DISP_Y1);
  localparam logic [8:0] VIS_X1  = 9'(`VIC_VIS_X1);
  localparam logic [8:0] VIS_Y0  = 9'(`VIC_VIS_Y0);
  localparam logic [8:0] VIS_Y1  = 9'(`VIC_VIS_Y1);

  logic visible;
  logic in_disp;

  assign visible = (xpos < VIS_X1) && (raster >= VIS_Y0) && (raster < VIS_Y1);
  assign in_disp = (xpos >= DISP_X0) && (xpos <= DISP_X1) &&
                   (raster >= DISP_Y0) && (raster <= DISP_Y1);

  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      rgb <= '0;
    end else if (!visible) begin
      rgb <= '0;                          // blanking, black level
    end else if (in_disp) begin
      rgb <= vic_palette[background];     // no char/bitmap, plain bg
    end else begin
      rgb <= vic_palette[border];
    end
  end

endmodule : pixel_out

//--- hw/vicii.sv
`timescale 1ns/1ps

module vicii (
  input  logic               clk_dot4x,
  input  logic               arst_n,
  input  vic_pkg::chip_t     chip,
  input  logic               ce,
  input  logic               rw,
  input  vic_pkg::reg_addr_t adi,
  input  logic [7:0]         dbi,
  output logic [7:0]         dbo,
  output logic [11:0]        ado,
  output logic               clk_phi,
  output logic               aec,
  output logic               ba,      // no dma, never asks for the bus
  output logic               ras,
  output logic               cas,
  output logic               vic_write_ab,
  output logic               vic_write_db,
  output logic               ls245_oe,
  output logic               ls245_dir,
  output logic               irq,
  output logic               hsync,
  output logic               vsync,
  output logic               csync,
  output logic [1:0]         red,
  output logic [1:0]         green,
  output logic [1:0]         blue
);
  import vic_pkg::*;

  logic       wr_stb;
  logic       dot_tick;
  logic       line_stb;
  logic [8:0] xpos;
  logic [8:0] raster;
  color_t     border;
  color_t     background;
  rgb2_t      rgb;

  bus_sequencer seq_i (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .ce           (ce),
    .rw           (rw),
    .clk_phi      (clk_phi),
    .aec          (aec),
    .ras          (ras),
    .cas          (cas),
    .ado          (ado),
    .vic_write_ab (vic_write_ab),
    .vic_write_db (vic_write_db),
    .ls245_oe     (ls245_oe),
    .ls245_dir    (ls245_dir),
    .wr_stb       (wr_stb),
    .dot_tick     (dot_tick)
  );

  raster_counter rc_i (
    .clk_dot4x (clk_dot4x),
    .arst_n    (arst_n),
    .chip      (chip),
    .dot_tick  (dot_tick),
    .xpos      (xpos),
    .raster    (raster),
    .line_stb  (line_stb),
    .hsync     (hsync),
    .vsync     (vsync),
    .csync     (csync)
  );

  reg_file regs_i (
    .clk_dot4x  (clk_dot4x),
    .arst_n     (arst_n),
    .adi        (adi),
    .dbi        (dbi),
    .wr_stb     (wr_stb),
    .raster     (raster),
    .line_stb   (line_stb),
    .dbo        (dbo),
    .irq        (irq),
    .border     (border),
    .background (background)
  );

  pixel_out pix_i (
    .clk_dot4x  (clk_dot4x),
    .arst_n     (arst_n),
    .xpos       (xpos),
    .raster     (raster),
    .border     (border),
    .background (background),
    .rgb        (rgb)
  );

  assign ba    = 1'b1;
  assign red   = rgb.red;
  assign green = rgb.green;
  assign blue  = rgb.blue;

endmodule : vicii

//--- hw/top.sv
`timescale 1ns/1ps

// board level, clocks and chip model come in from outside
module top (
  input  logic           clk_dot4x,   // 32x phi
  input  logic           clk_col4x,   // 4x colour subcarrier
  input  vic_pkg::chip_t chip,
  input  logic           arst_n,
  output logic           cpu_reset,   // to 6510 reset via jumper
  output logic           clk_colref,  // colour ref for the video encoder
  output logic           clk_phi,
  output logic           csync,
  output logic           hsync,
  output logic           vsync,
  output logic [1:0]     red,
  output logic [1:0]     green,
  output logic [1:0]     blue,
  inout  tri   [5:0]     adl,         // low address, vic reads these
  output tri   [5:0]     adh,
  inout  tri   [7:0]     dbl,
  input  logic [3:0]     dbh,         // colour ram nibble, no fetch in this core
  input  logic           ce,
  input  logic           rw,
  output logic           irq,
  input  logic           lp,          // light pen not implemented
  output logic           aec,
  output logic           ba,
  output logic           cas,
  output logic           ras,
  output logic           ls245_oe,
  output logic           ls245_dir
);

  logic [7:0]  dbo;
  logic [11:0] ado;
  logic        vic_write_ab;
  logic        vic_write_db;

  assign cpu_reset = !arst_n;  // cpu held while we are

  clk_div4 colref_i (
    .clk_col4x  (clk_col4x),
    .arst_n     (arst_n),
    .clk_colref (clk_colref)
  );

  vicii vic_i (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .chip         (chip),
    .ce           (ce),
    .rw           (rw),
    .adi          (adl),
    .dbi          (dbl),
    .dbo          (dbo),
    .ado          (ado),
    .clk_phi      (clk_phi),
    .aec          (aec),
    .ba           (ba),
    .ras          (ras),
    .cas          (cas),
    .vic_write_ab (vic_write_ab),
    .vic_write_db (vic_write_db),
    .ls245_oe     (ls245_oe),
    .ls245_dir    (ls245_dir),
    .irq          (irq),
    .hsync        (hsync),
    .vsync        (vsync),
    .csync        (csync),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  // drive only when we own the bus, float otherwise
  assign dbl = vic_write_db ? dbo : 8'bz;          // cpu read of a register
  assign adl = vic_write_ab ? ado[5:0] : 6'bz;     // refresh cycle
  assign adh = vic_write_ab ? ado[11:6] : 6'bz;

endmodule : top

//--- sim/tb_top.sv
`timescale 1ns/1ps

`include "vic_consts.svh"

module tb_top;
  import vic_pkg::*;

  localparam int LINE_CLKS  = `VIC_CYC_NTSC * `VIC_PHASES;   // 2080 clocks per ntsc line
  localparam int FRAME_CLKS = `VIC_LINES_NTSC * LINE_CLKS;
  localparam int PX_CLKS    = `VIC_PHASES / 8;               // 8 pixels per phi
  localparam int HS_CLKS    = `VIC_HSYNC_LEN * PX_CLKS;      // hsync low per line

  logic       clk_dot4x;
  logic       clk_col4x;
  logic       arst_n;
  chip_t      chip;
  logic       ce;
  logic       rw;
  logic [3:0] dbh;
  logic       lp;
  logic [5:0] adl_drv;    // cpu side of the address bus
  logic       adl_oe;
  logic [7:0] dbl_drv;
  logic       dbl_oe;
  wire  [5:0] adl;
  wire  [5:0] adh;
  wire  [7:0] dbl;
  logic       cpu_reset;
  logic       clk_colref;
  logic       clk_phi;
  logic       csync;
  logic       hsync;
  logic       vsync;
  logic [1:0] red;
  logic [1:0] green;
  logic [1:0] blue;
  logic       irq;
  logic       aec;
  logic       ba;
  logic       cas;
  logic       ras;
  logic       ls245_oe;
  logic       ls245_dir;

  integer seed;
  int     errors;
  int     checks;
  int     test_errs;
  int     tests;

  top dut_i (
    .clk_dot4x (clk_dot4x),
    .clk_col4x (clk_col4x),
    .chip      (chip),
    .arst_n    (arst_n),
    .cpu_reset (cpu_reset),
    .clk_colref(clk_colref),
    .clk_phi   (clk_phi),
    .csync     (csync),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .adl       (adl),
    .adh       (adh),
    .dbl       (dbl),
    .dbh       (dbh),
    .ce        (ce),
    .rw        (rw),
    .irq       (irq),
    .lp        (lp),
    .aec       (aec),
    .ba        (ba),
    .cas       (cas),
    .ras       (ras),
    .ls245_oe  (ls245_oe),
    .ls245_dir (ls245_dir)
  );

  assign adl = adl_oe ? adl_drv : 6'bz;  // cpu drives only in phi high
  assign dbl = dbl_oe ? dbl_drv : 8'bz;

  initial begin
    clk_dot4x = 1'b0;
    forever #10 clk_dot4x = ~clk_dot4x;
  end

  initial begin
    clk_col4x = 1'b0;
    forever #7 clk_col4x = ~clk_col4x;   // 14 ns colour clock
  end

  // bound on the whole run
  initial begin
    #200_000_000;
    $display("run did not finish within 200 ms of simulated time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic count_error();
    errors++;
    test_errs++;
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      count_error();
    end
  endtask

  task automatic cmp_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
      count_error();
    end
  endtask

  task automatic cmp_rgb(input string name, input rgb2_t got, input rgb2_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
      count_error();
    end
  endtask

  task automatic cmp_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      count_error();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done, %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  // sampled on falling edges away from the dut's rising edge
  task automatic wait_phi(input logic level, output bit ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_dot4x);
    while (clk_phi !== level && ok) begin
      @(negedge clk_dot4x);
      n++;
      if (n > 2 * `VIC_PHASES) begin
        $display("timeout: clk_phi never reached level %0b", level);
        count_error();
        ok = 1'b0;
      end
    end
  endtask

  task automatic wait_vsync_fall(output bit ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_dot4x);
    while (vsync !== 1'b1 && ok) begin   // leave any pulse in progress
      @(negedge clk_dot4x);
      n++;
      if (n > FRAME_CLKS + LINE_CLKS) begin
        $display("timeout: vsync stuck low");
        count_error();
        ok = 1'b0;
      end
    end
    while (vsync !== 1'b0 && ok) begin
      @(negedge clk_dot4x);
      n++;
      if (n > 2 * FRAME_CLKS) begin
        $display("timeout: no vsync pulse within a frame");
        count_error();
        ok = 1'b0;
      end
    end
  endtask

  task automatic wait_irq_low(output bit ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_dot4x);
    while (irq !== 1'b0 && ok) begin
      @(negedge clk_dot4x);
      n++;
      if (n > FRAME_CLKS + 2 * LINE_CLKS) begin
        $display("timeout: raster irq never fired");
        count_error();
        ok = 1'b0;
      end
    end
  endtask

  // one cpu access in the phi high half from phase 16 to phase 31
  task automatic bus_cycle(input logic wr, input reg_addr_t addr, input logic [7:0] wdata,
                           output logic [7:0] rdata);
    bit ok;
    rdata = 8'h00;
    wait_phi(1'b0, ok);
    if (ok) begin
      wait_phi(1'b1, ok);    // first high sample is phase 16
    end
    if (ok) begin
      @(posedge clk_dot4x);
      ce      <= 1'b0;
      rw      <= !wr;
      adl_drv <= addr;
      adl_oe  <= 1'b1;
      dbl_drv <= wdata;
      dbl_oe  <= wr;
      repeat (14) @(posedge clk_dot4x);  // up to phase 31
      @(negedge clk_dot4x);
      rdata = dbl;                        // vic drives dbl on reads here
      cmp_bit("ls245_oe", ls245_oe, 1'b0);  // buffer opened for the cpu
      cmp_bit("ls245_dir", ls245_dir, !wr);
      @(posedge clk_dot4x);               // write strobe edge then release the bus
      ce      <= 1'b1;
      rw      <= 1'b1;
      adl_oe  <= 1'b0;
      dbl_oe  <= 1'b0;
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input logic [7:0] data);
    logic [7:0] unused_rd;
    bus_cycle(1'b1, addr, data, unused_rd);
  endtask

  task automatic bus_read(input reg_addr_t addr, output logic [7:0] data);
    bus_cycle(1'b0, addr, 8'h00, data);
  endtask

  task automatic reset_values();
    logic v;
    int   n;
    repeat (2) @(posedge clk_dot4x);
    @(negedge clk_dot4x);                 // still inside reset
    cmp_bit("irq", irq, 1'b1);
    cmp_bit("ras", ras, 1'b1);
    cmp_bit("cas", cas, 1'b1);
    cmp_bit("ls245_oe", ls245_oe, 1'b1);
    cmp_bit("ls245_dir", ls245_dir, 1'b1);
    cmp_bit("clk_phi", clk_phi, 1'b0);
    cmp_bit("aec", aec, 1'b0);
    cmp_bit("vic_write_ab", dut_i.vic_write_ab, 1'b0);
    cmp_bit("cpu_reset", cpu_reset, 1'b1);
    cmp_bit("ba", ba, 1'b1);
    @(posedge clk_dot4x);
    arst_n <= 1'b1;
    // colour ref should flip every 2 input cycles once an edge is found
    n = 0;
    @(negedge clk_col4x);
    v = clk_colref;
    while (clk_colref === v && n <= 8) begin
      @(negedge clk_col4x);
      n++;
    end
    if (n > 8) begin
      $display("clk_colref never toggled");
      count_error();
    end
    v = clk_colref;
    for (int i = 1; i <= 8; i++) begin
      @(negedge clk_col4x);
      cmp_bit("clk_colref", clk_colref, v ^ i[1]);
    end
    cmp_bit("cpu_reset", cpu_reset, 1'b0);   // released with the core
    cmp_bit("ba", ba, 1'b1);
    end_test("reset");
  endtask

  task automatic phi_timing();
    bit         ok;
    bit         prev;
    int         n;
    int         ph;
    logic [5:0] last_row;
    wait_phi(1'b0, ok);
    wait_phi(1'b1, ok);                   // first high sample is phase 16
    n    = 0;
    prev = 1'b1;
    do begin
      @(negedge clk_dot4x);
      n++;
      ph = (16 + n) % `VIC_PHASES;
      cmp_bit("clk_phi", clk_phi, ph >= 16);
      cmp_bit("aec", aec, ph >= 16);
      cmp_bit("vic_write_ab", dut_i.vic_write_ab, ph < 16);  // vic owns addr in phi low
      cmp_bit("ras", ras, !(ph >= 6 && ph <= 13));
      cmp_bit("cas", cas, !(ph >= 22 && ph <= 29));          // ce high, cpu on dram
      cmp_bit("ls245_oe", ls245_oe, 1'b1);
      ok   = clk_phi && !prev;
      prev = clk_phi;
    end while (!ok && n < 3 * `VIC_PHASES);
    cmp_count("phi period", n, `VIC_PHASES);
    last_row = 6'd0;
    for (int i = 0; i < 4; i++) begin
      wait_phi(1'b1, ok);
      wait_phi(1'b0, ok);                 // phase 0 carries the refresh address
      cmp_byte("adh", {2'b00, adh}, 8'h3F);
      if (i > 0) begin
        cmp_byte("adl", {2'b00, adl}, {2'b00, last_row + 6'd1});
      end
      last_row = adl;
    end
    end_test("phi_timing");
  endtask

  task automatic reg_readback();
    logic [31:0] r;
    logic [7:0]  rd;
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      bus_write(`VIC_REG_BORDER, r[7:0]);
      bus_read(`VIC_REG_BORDER, rd);
      cmp_byte("border reg", rd, r[7:0]);
      bus_write(`VIC_REG_BG, r[15:8]);
      bus_read(`VIC_REG_BG, rd);
      cmp_byte("bg reg", rd, r[15:8]);
    end
    bus_read(6'h3F, rd);                  // nothing mapped there
    cmp_byte("unused reg", rd, 8'hFF);
    end_test("reg_rw");
  endtask

  task automatic raster_irq();
    logic [31:0] r;
    logic [8:0]  line;
    logic [7:0]  rd;
    bit          ok;
    r    = $random(seed);
    line = r[8:0] % 9'd263;               // any ntsc line
    bus_write(`VIC_REG_RASTER, line[7:0]);
    bus_write(`VIC_REG_CTRL1, {line[8], 7'd0});
    bus_write(`VIC_REG_IRQ, 8'h01);       // drop any old status first
    bus_write(`VIC_REG_IRQEN, 8'h01);
    wait_irq_low(ok);
    if (ok) begin
      bus_read(`VIC_REG_RASTER, rd);
      cmp_byte("raster", rd, line[7:0]);
      bus_read(`VIC_REG_CTRL1, rd);
      cmp_bit("raster bit 8", rd[7], line[8]);
      bus_read(`VIC_REG_IRQ, rd);
      cmp_bit("irq status", rd[0], 1'b1);
      cmp_bit("irq active", rd[7], 1'b1);
      bus_write(`VIC_REG_IRQ, 8'h01);     // ack
      @(negedge clk_dot4x);
      cmp_bit("irq", irq, 1'b1);
      bus_read(`VIC_REG_IRQ, rd);
      cmp_bit("irq status", rd[0], 1'b0);
    end
    end_test("raster_irq");
  endtask

  // clocks from the vsync sample to the middle of pixel x on line y
  function automatic int clocks_to(input int y, input int x);
    return (y - `VIC_VSYNC_LINE) * LINE_CLKS + 4 * x + 1;
  endfunction

  task automatic pixel_colours();
    logic [31:0] r;
    color_t      bdr;
    color_t      bg;
    rgb2_t       got;
    bit          ok;
    int          done;
    int          ys [4];
    int          xs [4];
    rgb2_t       exp [4];
    r   = $random(seed);
    bdr = r[3:0];
    bg  = r[7:4];
    if (bdr == 4'd0) begin
      bdr = 4'd1;                         // keep border apart from black
    end
    if (bg == bdr || bg == 4'd0) begin
      bg = (bdr == 4'hF) ? 4'h1 : bdr + 4'h1;  // neither border nor black
    end
    bus_write(`VIC_REG_BORDER, {4'h0, bdr});
    bus_write(`VIC_REG_BG, {4'h0, bg});
    // vertical blank, left border, mid screen, lower border
    ys  = '{8, 60, 150, 255};
    xs  = '{200, 10, 184, 200};
    exp = '{rgb2_t'(6'd0), vic_palette[bdr], vic_palette[bg], vic_palette[bdr]};
    wait_vsync_fall(ok);
    done = 0;
    for (int i = 0; i < 4 && ok; i++) begin
      repeat (clocks_to(ys[i], xs[i]) - done) @(posedge clk_dot4x);
      done = clocks_to(ys[i], xs[i]);
      @(negedge clk_dot4x);
      got = {red, green, blue};
      cmp_rgb("rgb", got, exp[i]);
    end
    end_test("pixels");
  endtask

  task automatic frame_period();
    bit ok;
    bit prev;
    int n;
    int hs_low;
    int cs_low;
    wait_vsync_fall(ok);
    n      = 0;
    hs_low = 0;
    cs_low = 0;
    prev   = 1'b0;
    while (ok) begin
      @(negedge clk_dot4x);
      n++;
      if (!hsync) begin
        hs_low++;
      end
      if (!csync) begin
        cs_low++;
      end
      if (prev && !vsync) begin
        ok = 1'b0;                        // next falling edge
      end
      prev = vsync;
      if (n > 2 * FRAME_CLKS) begin
        $display("timeout: second vsync pulse missing");
        count_error();
        ok = 1'b0;
      end
    end
    cmp_count("frame clocks", n, FRAME_CLKS);
    cmp_count("hsync low clocks", hs_low, `VIC_LINES_NTSC * HS_CLKS);
    // vsync lines add their clocks outside the hsync pulse
    cmp_count("csync low clocks", cs_low,
              `VIC_LINES_NTSC * HS_CLKS + `VIC_VSYNC_LEN * (LINE_CLKS - HS_CLKS));
    end_test("frame_period");
  endtask

  initial begin
    seed      = 32'hc945_67b5;
    errors    = 0;
    checks    = 0;
    test_errs = 0;
    tests     = 0;
    arst_n    = 1'b0;
    chip      = chip_ntsc;
    ce        = 1'b1;                     // not selected
    rw        = 1'b1;
    dbh       = 4'h0;
    lp        = 1'b1;
    adl_drv   = 6'h00;
    adl_oe    = 1'b0;
    dbl_drv   = 8'h00;
    dbl_oe    = 1'b0;
    reset_values();
    phi_timing();
    reg_readback();
    raster_irq();
    pixel_colours();
    frame_period();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_top

//--- vlog.f
+incdir+hw
hw/vic_pkg.sv
hw/clk_div4.sv
hw/bus_sequencer.sv
hw/raster_counter.sv
hw/reg_file.sv
hw/pixel_out.sv
hw/vicii.sv
hw/top.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build tb_top with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_top -Mdir "$OBJ" -o tb_top -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi

exit 0
